// File: vlsu_cfg.svh
//******************************
// sizes of the vector load/store unit
// one line = one vector register = VLEN bits over all banks
// group width must equal VLEN * max beats
//******************************
`ifndef VLSU_CFG_SVH
`define VLSU_CFG_SVH

`define VLSU_VLEN      128   // vector register width, also the memory line
`define VLSU_BANK_W    32    // width of one memory bank
`define VLSU_BANKS     4     // banks per line

// memory line address, not byte address
`define VLSU_ADR_W     14

`define VLSU_MAX_BEATS 4     // lmul 4 is the largest group
`define VLSU_GROUP_W   (`VLSU_VLEN * `VLSU_MAX_BEATS)

// stride is counted in elements
`define VLSU_STRIDE_W  6

`endif

// File: vlsu_pkg.sv
//******************************
// types shared by the load/store unit
// spare sew code behaves as e32, spare lmul code as m1
//******************************
`include "vlsu_cfg.svh"

package vlsu_pkg;

    // operation select from the host
    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_load  = 2'd1,   // unit stride load
        op_store = 2'd2,   // unit stride store
        op_sload = 2'd3    // strided load
    } vlsu_op_e;

    typedef enum logic [1:0] {
        sew_e8  = 2'd0,
        sew_e16 = 2'd1,
        sew_e32 = 2'd2,
        sew_rsv = 2'd3     // treated like e32
    } vlsu_sew_e;

    typedef enum logic [1:0] {
        lmul_m1  = 2'd0,
        lmul_m2  = 2'd1,
        lmul_m4  = 2'd2,
        lmul_rsv = 2'd3    // treated like m1
    } vlsu_lmul_e;

    typedef logic [`VLSU_VLEN-1:0]     line_t;    // one memory line
    typedef logic [`VLSU_GROUP_W-1:0]  group_t;   // whole register group
    typedef logic [`VLSU_ADR_W-1:0]    adr_t;     // line address
    typedef logic [2:0]                beats_t;   // 1 to 4 lines
    typedef logic [`VLSU_STRIDE_W-1:0] stride_t;  // elements between picks

endpackage

// File: vlsu_cmd_reg.sv
//******************************
// command register of the unit
// start is only legal while ready is high
// outputs show the new command already in the start cycle
//******************************
`timescale 1ns/1ps

module vlsu_cmd_reg (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 start,
    input  vlsu_pkg::vlsu_op_e   op,
    input  vlsu_pkg::vlsu_lmul_e lmul,
    input  vlsu_pkg::vlsu_sew_e  sew,
    input  vlsu_pkg::stride_t    stride,
    input  vlsu_pkg::adr_t       base_adr,
    input  logic                 done,
    output logic                 ready,
    output logic                 go,
    output vlsu_pkg::vlsu_op_e   op_q,
    output vlsu_pkg::vlsu_sew_e  sew_q,
    output vlsu_pkg::stride_t    stride_q,
    output vlsu_pkg::adr_t       base_q,
    output vlsu_pkg::beats_t     beats
);
    import vlsu_pkg::*;

    logic      busy;       // a command is in flight
    vlsu_op_e  op_r;
    vlsu_sew_e sew_r;
    stride_t   stride_r;
    adr_t      base_r;
    beats_t    beats_r;

    // lines per register group
    function automatic beats_t lmul_beats(input vlsu_lmul_e m);
        case (m)
            lmul_m2: return 3'd2;
            lmul_m4: return 3'd4;
            default: return 3'd1;  // m1 and the spare code
        endcase
    endfunction

    assign ready = !busy;
    assign go    = start && !busy;  // accepted this cycle

    // bypass so seq and datapaths act in the start cycle
    assign op_q     = go ? op : op_r;
    assign sew_q    = go ? sew : sew_r;
    assign stride_q = go ? stride : stride_r;
    assign base_q   = go ? base_adr : base_r;
    assign beats    = go ? lmul_beats(lmul) : beats_r;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy <= 1'b0;
            op_r <= op_idle;
        end else if (go) begin
            busy <= 1'b1;
            op_r <= op;
        end else if (done) begin
            busy <= 1'b0;  // ready again next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            sew_r    <= sew;
            stride_r <= stride;
            base_r   <= base_adr;
            beats_r  <= lmul_beats(lmul);
        end
    end

    // host must wait for ready
    a_start_ready: assert property (@(posedge clk) disable iff (!nrst)
        start |-> ready);

    // sequencer only finishes a command that was accepted
    a_done_busy: assert property (@(posedge clk) disable iff (!nrst)
        done |-> busy);

endmodule

// File: vlsu_seq.sv
//******************************
// beat sequencer and wishbone classic master
// one line per beat, addresses base .. base+beats-1
// ack is the only response with no retry or error
//******************************
`timescale 1ns/1ps

module vlsu_seq (
    input  logic               clk,
    input  logic               nrst,
    input  logic               go,
    input  vlsu_pkg::vlsu_op_e op_q,
    input  vlsu_pkg::adr_t     base_q,
    input  vlsu_pkg::beats_t   beats,
    input  logic               wb_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output vlsu_pkg::adr_t     wb_adr,
    output logic               beat_ack,
    output logic               last_beat,
    output logic               done
);
    import vlsu_pkg::*;

    logic   active;   // bus cycle open
    beats_t cnt;      // beats already acked
    logic   fin;      // current beat is the final one
    logic   bus_op;

    assign bus_op = (op_q != op_idle);  // idle command finishes without the bus

    // cyc and stb move together in classic single transfers
    assign wb_cyc = active;
    assign wb_stb = active;

    assign beat_ack  = active && wb_ack;
    assign fin       = (cnt == beats - 3'd1);
    assign last_beat = beat_ack && fin;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            active <= 1'b0;
            wb_we  <= 1'b0;
            cnt    <= '0;
            done   <= 1'b0;
        end else begin
            done <= last_beat || (go && !bus_op);  // one cycle after last ack
            if (go && bus_op) begin
                active <= 1'b1;
                wb_we  <= (op_q == op_store);
                cnt    <= '0;
            end else if (beat_ack) begin
                cnt <= cnt + 3'd1;
                if (fin) begin
                    active <= 1'b0;  // drop on edge after last ack
                    wb_we  <= 1'b0;
                end
            end
        end
    end

    // line address steps after each ack
    always_ff @(posedge clk) begin
        if (go) begin
            wb_adr <= base_q;
        end else if (beat_ack) begin
            wb_adr <= wb_adr + 1'b1;
        end
    end

    // the bus cycle closes only on the edge after the final ack
    a_cyc_end: assert property (@(posedge clk) disable iff (!nrst)
        $fell(wb_cyc) |-> $past(last_beat));

    // a waiting strobe keeps its address through wait states
    a_adr_hold: assert property (@(posedge clk) disable iff (!nrst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

// File: vlsu_load_pack.sv
//******************************
// load assembly and stride compaction
// beat k lands in bits 128k upward
// strided result is built in the edge of the last ack
//******************************
`timescale 1ns/1ps
`include "vlsu_cfg.svh"

module vlsu_load_pack (
    input  logic                clk,
    input  logic                nrst,
    input  logic                go,
    input  vlsu_pkg::vlsu_op_e  op_q,
    input  vlsu_pkg::vlsu_sew_e sew_q,
    input  vlsu_pkg::stride_t   stride_q,
    input  vlsu_pkg::beats_t    beats,
    input  vlsu_pkg::line_t     wb_dat_i,
    input  logic                beat_ack,
    input  logic                last_beat,
    output vlsu_pkg::group_t    load_data
);
    import vlsu_pkg::*;

    localparam int slot_w      = $clog2(`VLSU_MAX_BEATS);
    localparam int line_bytes  = `VLSU_VLEN / 8;
    localparam int group_bytes = `VLSU_GROUP_W / 8;

    logic              is_load;
    logic [slot_w-1:0] slot;       // next line slot
    group_t            gbuf;       // lines gathered so far
    group_t            gathered;   // gbuf plus the line on the bus
    group_t            compacted;
    logic [1:0]        esh;        // log2 of element bytes

    // pick element i*s for every result element, zero past the gathered ones
    function automatic group_t compact(input group_t g, input logic [1:0] sh,
                                       input stride_t s, input beats_t nb);
        group_t      r;
        int unsigned elem;
        int unsigned src;
        int unsigned limit;
        r     = '0;
        limit = nb * line_bytes;  // gathered bytes
        if (s < 2) begin
            r = g;
        end else begin
            for (int b = 0; b < group_bytes; b++) begin
                elem = b >> sh;
                src  = ((elem * s) << sh) | (b & ((1 << sh) - 1));  // byte inside elem kept
                if (src < limit) begin
                    r[b*8 +: 8] = g[src*8 +: 8];
                end
            end
        end
        return r;
    endfunction

    assign is_load = (op_q == op_load) || (op_q == op_sload);

    always_comb begin
        case (sew_q)
            sew_e8:  esh = 2'd0;
            sew_e16: esh = 2'd1;
            default: esh = 2'd2;  // e32 and spare
        endcase
    end

    always_comb begin
        gathered = gbuf;
        gathered[slot*`VLSU_VLEN +: `VLSU_VLEN] = wb_dat_i;
    end

    assign compacted = (op_q == op_sload) ? compact(gathered, esh, stride_q, beats) : gathered;

    // unused slots stay zero for short groups
    always_ff @(posedge clk) begin
        if (go && is_load) begin
            gbuf <= '0;
        end else if (beat_ack && is_load) begin
            gbuf <= gathered;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            slot      <= '0;
            load_data <= '0;
        end else begin
            if (go) begin
                slot <= '0;
            end else if (beat_ack && is_load) begin
                slot <= slot + 1'b1;
            end
            if (last_beat && is_load) begin
                load_data <= compacted;  // same edge as done
            end
        end
    end

endmodule

// File: vlsu_store_buf.sv
//******************************
// store data register
// whole group captured on go, lowest line goes out first
//******************************
`timescale 1ns/1ps
`include "vlsu_cfg.svh"

module vlsu_store_buf (
    input  logic             clk,
    input  logic             nrst,
    input  logic             go,
    input  vlsu_pkg::group_t store_data,
    input  logic             beat_ack,
    output vlsu_pkg::line_t  wb_dat_o
);
    import vlsu_pkg::*;

    group_t sd_q;  // lines still to be written, next one at the bottom

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sd_q <= '0;
        end else if (go) begin
            sd_q <= store_data;
        end else if (beat_ack) begin
            sd_q <= sd_q >> `VLSU_VLEN;  // next line moves down
        end
    end

    assign wb_dat_o = sd_q[`VLSU_VLEN-1:0];

    // first strobe is a cycle after go, so no ack can meet a fresh capture
    a_go_no_ack: assert property (@(posedge clk) disable iff (!nrst)
        go |-> !beat_ack);

endmodule

// File: vlsu_top.sv
//******************************
// vector load/store unit top
// wishbone classic master, one 128-bit line per beat
// only full lines are written, no byte select
//******************************
`timescale 1ns/1ps

module vlsu_top (
    input  logic                 clk,
    input  logic                 nrst,
    // command side
    input  logic                 start,
    input  vlsu_pkg::vlsu_op_e   op,
    input  vlsu_pkg::vlsu_lmul_e lmul,
    input  vlsu_pkg::vlsu_sew_e  sew,
    input  vlsu_pkg::stride_t    stride,
    input  vlsu_pkg::adr_t       base_adr,
    input  vlsu_pkg::group_t     store_data,
    output logic                 ready,
    output logic                 done,
    output vlsu_pkg::group_t     load_data,
    // memory side
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output vlsu_pkg::adr_t       wb_adr,
    output vlsu_pkg::line_t      wb_dat_o,
    input  vlsu_pkg::line_t      wb_dat_i,
    input  logic                 wb_ack
);
    import vlsu_pkg::*;

    logic      go;
    vlsu_op_e  op_q;
    vlsu_sew_e sew_q;
    stride_t   stride_q;
    adr_t      base_q;
    beats_t    beats;
    logic      beat_ack;   // one beat done
    logic      last_beat;

    vlsu_cmd_reg u_cmd (
        .clk      (clk),
        .nrst     (nrst),
        .start    (start),
        .op       (op),
        .lmul     (lmul),
        .sew      (sew),
        .stride   (stride),
        .base_adr (base_adr),
        .done     (done),
        .ready    (ready),
        .go       (go),
        .op_q     (op_q),
        .sew_q    (sew_q),
        .stride_q (stride_q),
        .base_q   (base_q),
        .beats    (beats)
    );

    vlsu_seq u_seq (
        .clk       (clk),
        .nrst      (nrst),
        .go        (go),
        .op_q      (op_q),
        .base_q    (base_q),
        .beats     (beats),
        .wb_ack    (wb_ack),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .beat_ack  (beat_ack),
        .last_beat (last_beat),
        .done      (done)
    );

    vlsu_load_pack u_load (
        .clk       (clk),
        .nrst      (nrst),
        .go        (go),
        .op_q      (op_q),
        .sew_q     (sew_q),
        .stride_q  (stride_q),
        .beats     (beats),
        .wb_dat_i  (wb_dat_i),
        .beat_ack  (beat_ack),
        .last_beat (last_beat),
        .load_data (load_data)
    );

    vlsu_store_buf u_store (
        .clk        (clk),
        .nrst       (nrst),
        .go         (go),
        .store_data (store_data),
        .beat_ack   (beat_ack),
        .wb_dat_o   (wb_dat_o)
    );

endmodule

// File: tb_wb_mem.sv
//******************************
// wishbone classic slave memory
// one 128-bit line per address
// 0 to 3 wait states before each ack
// fill_random draws from the caller's seeded $urandom
//******************************
`timescale 1ns/1ps
`include "vlsu_cfg.svh"

module tb_wb_mem (
    input  logic            clk,
    input  logic            nrst,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  vlsu_pkg::adr_t  wb_adr,
    input  vlsu_pkg::line_t wb_dat_i,
    output vlsu_pkg::line_t wb_dat_o,
    output logic            wb_ack
);
    import vlsu_pkg::*;

    localparam int depth = 1 << `VLSU_ADR_W;

    line_t      ram [depth];
    logic [1:0] wait_n;  // wait states left for the current request

    // random words, xor with the address so every line differs
    task automatic fill_random();
        for (int a = 0; a < depth; a++) begin
            ram[a] = {$urandom, $urandom, $urandom, $urandom} ^ line_t'(a);
        end
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            wait_n   <= 2'd0;
        end else begin
            wb_ack <= 1'b0;  // ack lasts one cycle
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_n != 2'd0) begin
                    wait_n <= wait_n - 2'd1;
                end else begin
                    wb_ack <= 1'b1;
                    if (wb_we) begin
                        ram[wb_adr] <= wb_dat_i;
                    end else begin
                        wb_dat_o <= ram[wb_adr];  // valid in the ack cycle
                    end
                    wait_n <= 2'($urandom_range(3, 0));  // for the next request
                end
            end
        end
    end

endmodule

// File: tb_vlsu.sv
//******************************
// testbench of the load/store unit
// random commands from a fixed seed are checked against a memory mirror
// inputs change on the falling edge and outputs are sampled there
//******************************
`timescale 1ns/1ps
`include "vlsu_cfg.svh"

module tb_vlsu;
    import vlsu_pkg::*;

    localparam int n_cmds      = 200;
    localparam int depth       = 1 << `VLSU_ADR_W;
    localparam int words       = `VLSU_GROUP_W / `VLSU_BANK_W;
    // at most 5 cycles a beat plus the start and done cycles per command
    // readbacks after stores can double the command count
    localparam int cycle_limit = 2 * n_cmds * (`VLSU_MAX_BEATS * 5 + 2) + 500;

    logic       clk;
    logic       nrst;
    logic       start;
    vlsu_op_e   op;
    vlsu_lmul_e lmul;
    vlsu_sew_e  sew;
    stride_t    stride;
    adr_t       base_adr;
    group_t     store_data;
    logic       ready;
    logic       done;
    group_t     load_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    adr_t       wb_adr;
    line_t      wb_dat_o;
    line_t      wb_dat_i;
    logic       wb_ack;

    line_t  mirror [depth];  // expected memory contents
    group_t last_load;       // load_data must hold this across stores
    int     cyc_n = 0;

    vlsu_top uut (.*);

    tb_wb_mem mem (
        .clk      (clk),
        .nrst     (nrst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_o),  // master out to slave in
        .wb_dat_o (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "run stopped: %s", why);
    endtask

    // cycle counter and watchdog
    always @(posedge clk) begin
        cyc_n <= cyc_n + 1;
        if (cyc_n >= cycle_limit) begin
            abort_run("timeout, the unit stopped finishing commands");
        end
    end

    task automatic check_group(input string name, input group_t exp, input group_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h actual %h", name, exp, act);
            abort_run("group mismatch");
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h actual %h", name, exp, act);
            abort_run("line mismatch");
        end
    endtask

    task automatic check_adr(input string name, input adr_t exp, input adr_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h actual %h", name, exp, act);
            abort_run("address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %b actual %b", name, exp, act);
            abort_run("control mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error %s: expected %0d actual %0d", name, exp, act);
            abort_run("count mismatch");
        end
    endtask

    // spare codes fall back to m1 and e32
    function automatic int beats_of(input vlsu_lmul_e m);
        return (m == lmul_m2) ? 2 : (m == lmul_m4) ? 4 : 1;
    endfunction

    function automatic int elem_bytes(input vlsu_sew_e e);
        return (e == sew_e8) ? 1 : (e == sew_e16) ? 2 : 4;
    endfunction

    function automatic group_t gather(input adr_t b, input int nb);
        group_t g;
        g = '0;  // slots past the group stay zero
        for (int k = 0; k < nb; k++) begin
            g[k*`VLSU_VLEN +: `VLSU_VLEN] = mirror[adr_t'(b + k)];
        end
        return g;
    endfunction

    // element i takes element i*s and stays zero once i*s runs past the gathered ones
    function automatic group_t stride_pick(input group_t g, input int w, input int s,
                                           input int nb);
        group_t r;
        int     ne;
        r  = '0;
        ne = nb * 16 / w;
        if (s < 2) begin
            return g;
        end
        for (int i = 0; i < ne; i++) begin
            if (i * s < ne) begin
                for (int j = 0; j < w; j++) begin
                    r[(i*w + j)*8 +: 8] = g[(i*s*w + j)*8 +: 8];
                end
            end
        end
        return r;
    endfunction

    task automatic run_cmd(input string tname, input vlsu_op_e o, input vlsu_lmul_e m,
                           input vlsu_sew_e e, input stride_t s, input adr_t b,
                           input group_t sd);
        int     nb;
        int     acks;
        int     last_ack;
        group_t exp;
        nb       = beats_of(m);
        acks     = 0;
        last_ack = -1;
        check_bit({tname, " ready before start"}, 1'b1, ready);
        start      = 1'b1;
        op         = o;
        lmul       = m;
        sew        = e;
        stride     = s;
        base_adr   = b;
        store_data = sd;
        @(negedge clk);
        start = 1'b0;
        check_bit({tname, " ready while busy"}, 1'b0, ready);
        check_bit({tname, " strobe after start"}, 1'b1, wb_stb);
        while (done !== 1'b1) begin
            if (wb_cyc && wb_stb && wb_ack) begin
                check_adr({tname, " beat address"}, adr_t'(b + acks), wb_adr);
                check_bit({tname, " write enable"}, o == op_store, wb_we);
                if (o == op_store) begin
                    check_line({tname, " store line"}, sd[acks*`VLSU_VLEN +: `VLSU_VLEN],
                               wb_dat_o);
                    mirror[adr_t'(b + acks)] = sd[acks*`VLSU_VLEN +: `VLSU_VLEN];
                end
                acks++;
                last_ack = cyc_n;
            end
            @(negedge clk);
        end
        check_count({tname, " acked beats"}, nb, acks);
        check_count({tname, " done latency"}, last_ack + 1, cyc_n);
        check_bit({tname, " cyc dropped"}, 1'b0, wb_cyc);
        if (o == op_store) begin
            check_group({tname, " load data held"}, last_load, load_data);
        end else begin
            exp = gather(b, nb);
            if (o == op_sload) begin
                exp = stride_pick(exp, elem_bytes(e), int'(s), nb);
            end
            check_group({tname, " load data"}, exp, load_data);
            last_load = exp;
        end
        @(negedge clk);
        check_bit({tname, " done pulse"}, 1'b0, done);
        check_bit({tname, " ready after done"}, 1'b1, ready);
    endtask

    initial begin
        vlsu_op_e   o;
        vlsu_lmul_e m;
        vlsu_sew_e  e;
        stride_t    s;
        adr_t       b;
        group_t     sd;
        void'($urandom(32'h5b0dd473));
        clk        = 1'b0;
        nrst       = 1'b0;
        start      = 1'b0;
        op         = op_idle;
        lmul       = lmul_m1;
        sew        = sew_e8;
        stride     = '0;
        base_adr   = '0;
        store_data = '0;
        last_load  = '0;
        mem.fill_random();
        for (int i = 0; i < depth; i++) begin
            mirror[i] = mem.ram[i];
        end
        repeat (4) @(negedge clk);
        nrst = 1'b1;
        check_bit("reset ready", 1'b1, ready);
        check_bit("reset done", 1'b0, done);
        check_bit("reset cyc", 1'b0, wb_cyc);
        check_bit("reset stb", 1'b0, wb_stb);
        check_bit("reset we", 1'b0, wb_we);
        check_group("reset load data", '0, load_data);
        @(negedge clk);
        for (int n = 0; n < n_cmds; n++) begin
            o = vlsu_op_e'($urandom_range(3, 1));   // load, store or strided load
            m = vlsu_lmul_e'($urandom_range(3, 0)); // spare code included
            e = vlsu_sew_e'($urandom_range(3, 0));
            // small strides half the time and large ones that mostly zero the result
            s = stride_t'($urandom_range(1, 0) ? $urandom_range(7, 0) : $urandom_range(63, 0));
            b = adr_t'($urandom);
            for (int j = 0; j < words; j++) begin
                sd[j*32 +: 32] = $urandom;
            end
            run_cmd($sformatf("cmd %0d", n), o, m, e, s, b, sd);
            if (o == op_store) begin
                run_cmd($sformatf("cmd %0d readback", n), op_load, m, sew_e32, '0, b, '0);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
vlsu_pkg.sv
vlsu_cmd_reg.sv
vlsu_seq.sv
vlsu_load_pack.sv
vlsu_store_buf.sv
vlsu_top.sv
tb_wb_mem.sv
tb_vlsu.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_vlsu
RTL_TOP    := vlsu_top
FILELIST   := list.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
